/* rtl/ram_defs.svh */
// Width, depth and latency macros for the RAM controller

`ifndef RAM_DEFS_SVH
`define RAM_DEFS_SVH

//////////////////////////////
// Data path

`define RAM_DATA_W      32

//////////////////////////////
// SDRAM main memory

`define SDRAM_ADDR_W    22

// Installed words, anything above reads as all ones
`define DRAM_WORDS      16384

// Access timer load value
`define SDRAM_LATENCY   4

//////////////////////////////
// Video RAM

`define VRAM_ADDR_W     15
`define VRAM_WORDS      21504

// Request to ready delays, in cycles
`define VRAM_CPU_DELAY  4
`define VRAM_VGA_DELAY  1

`endif

/* rtl/mem_types_pkg.sv */
// Data word, address and memory command types

`include "ram_defs.svh"

package mem_types_pkg;

   // One data word
   typedef logic [`RAM_DATA_W-1:0] ram_word_t;

   // Word addresses
   typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;
   typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

   // Command from the sequencer to the word store
   typedef enum logic [1:0]
   {
      CMD_NONE  = 2'd0,
      CMD_READ  = 2'd1,
      CMD_WRITE = 2'd2
   } mem_cmd_e;

endpackage

/* rtl/ctrl_types_pkg.sv */
// SDRAM access state type

package ctrl_types_pkg;

   // Read and write each go access, busy, wait
   typedef enum logic [2:0]
   {
      SD_IDLE       = 3'd0,
      SD_READ       = 3'd1,
      SD_READ_BUSY  = 3'd2,
      SD_READ_WAIT  = 3'd3,
      SD_WRITE      = 3'd4,
      SD_WRITE_BUSY = 3'd5,
      SD_WRITE_WAIT = 3'd6
   } sdram_state_e;

endpackage

/* rtl/access_timer.sv */
// Down-counter standing in for the SDRAM command latency

`timescale 1ns/1ps

`include "ram_defs.svh"

module access_timer
   import mem_types_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic done
);

   localparam int CNT_W = $clog2(`SDRAM_LATENCY + 1);

   logic [CNT_W-1:0] count;

   //////////////////////////////
   // Counter

   // Zero means idle
   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (start)
         count <= CNT_W'(`SDRAM_LATENCY);
      else if (count != '0)
         count <= count - CNT_W'(1);
   end

   // Single pulse as the count hits zero
   always_ff @(posedge clk)
   begin
      if (reset)
         done <= 1'b0;
      else
         done <= !start && (count == CNT_W'(1));
   end

endmodule

/* rtl/sdram_store.sv */
// SDRAM word array with range check and read data register

`timescale 1ns/1ps

`include "ram_defs.svh"

module sdram_store
   import mem_types_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  mem_cmd_e    mem_cmd,
   input  sdram_addr_t addr,
   input  ram_word_t   wdata,
   output ram_word_t   rdata
);

   localparam int IDX_W = $clog2(`DRAM_WORDS);

   ram_word_t        mem [`DRAM_WORDS];
   logic             in_range;
   logic [IDX_W-1:0] idx;

   initial
   begin
      for (int i = 0; i < `DRAM_WORDS; i++)
         mem[i] = '0;
   end

   // Above installed memory
   assign in_range = addr < sdram_addr_t'(`DRAM_WORDS);
   assign idx      = addr[IDX_W-1:0];

   //////////////////////////////
   // Write port

   // Out of range writes are dropped
   always_ff @(posedge clk)
   begin
      if ((mem_cmd == CMD_WRITE) && in_range)
         mem[idx] <= wdata;
   end

   //////////////////////////////
   // Read port

   always_ff @(posedge clk)
   begin
      if (reset)
         rdata <= '0;
      else if (mem_cmd == CMD_READ)
         rdata <= in_range ? mem[idx] : '1;
   end

endmodule

/* rtl/sdram_fsm.sv */
// SDRAM access sequencer with ready and done registers

`timescale 1ns/1ps

`include "ram_defs.svh"

module sdram_fsm
   import mem_types_pkg::*;
   import ctrl_types_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sdram_req,
   input  logic     sdram_write,
   input  logic     timer_done,
   output logic     timer_start,
   output mem_cmd_e mem_cmd,
   output logic     sdram_ready,
   output logic     sdram_done
);

   sdram_state_e state;
   sdram_state_e state_next;

   //////////////////////////////
   // State register

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= SD_IDLE;
      else
         state <= state_next;
   end

   // Read wins when both levels are up
   always_comb
   begin
      state_next = state;
      case (state)
         SD_IDLE:
         begin
            if (sdram_req)
               state_next = SD_READ;
            else if (sdram_write)
               state_next = SD_WRITE;
         end
         SD_READ:       state_next = SD_READ_BUSY;
         SD_READ_BUSY:  if (timer_done) state_next = SD_READ_WAIT;
         SD_READ_WAIT:  if (!sdram_req) state_next = SD_IDLE;
         SD_WRITE:      state_next = SD_WRITE_BUSY;
         SD_WRITE_BUSY: if (timer_done) state_next = SD_WRITE_WAIT;
         SD_WRITE_WAIT: if (!sdram_write) state_next = SD_IDLE;
         default:       state_next = SD_IDLE;
      endcase
   end

   //////////////////////////////
   // Access strobes

   assign timer_start = (state == SD_READ) || (state == SD_WRITE);

   always_comb
   begin
      case (state)
         SD_READ:  mem_cmd = CMD_READ;
         SD_WRITE: mem_cmd = CMD_WRITE;
         default:  mem_cmd = CMD_NONE;
      endcase
   end

   //////////////////////////////
   // Handshake outputs

   // Follow the request level while waiting
   always_ff @(posedge clk)
   begin
      if (reset)
         sdram_ready <= 1'b0;
      else if (state == SD_READ)
         sdram_ready <= 1'b0;
      else if (state == SD_READ_WAIT)
         sdram_ready <= sdram_req;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         sdram_done <= 1'b0;
      else if (state == SD_WRITE)
         sdram_done <= 1'b0;
      else if (state == SD_WRITE_WAIT)
         sdram_done <= sdram_write;
   end

endmodule

/* rtl/vram_dpram.sv */
// Dual-port video RAM with ready delay lines and VGA hold register

`timescale 1ns/1ps

`include "ram_defs.svh"

module vram_dpram
   import mem_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  vram_addr_t cpu_addr,
   input  ram_word_t  cpu_wdata,
   input  logic       cpu_req,
   input  logic       cpu_write,
   input  vram_addr_t vga_addr,
   input  logic       vga_req,
   output ram_word_t  cpu_rdata,
   output logic       cpu_ready,
   output ram_word_t  vga_rdata,
   output logic       vga_ready
);

   ram_word_t mem [`VRAM_WORDS];
   ram_word_t vga_q;
   ram_word_t vga_hold;

   // Tap 0 is the request itself
   logic [`VRAM_CPU_DELAY:0] cpu_taps;
   logic [`VRAM_VGA_DELAY:0] vga_taps;

   //////////////////////////////
   // CPU port

   always_ff @(posedge clk)
   begin
      if (cpu_write && (cpu_addr < vram_addr_t'(`VRAM_WORDS)))
         mem[cpu_addr] <= cpu_wdata;
      if (cpu_req)
         cpu_rdata <= (cpu_addr < vram_addr_t'(`VRAM_WORDS)) ? mem[cpu_addr] : '0;
   end

   //////////////////////////////
   // VGA port

   always_ff @(posedge clk)
   begin
      if (vga_req)
         vga_q <= (vga_addr < vram_addr_t'(`VRAM_WORDS)) ? mem[vga_addr] : '0;
   end

   // Keeps the display word between fetches
   always_ff @(posedge clk)
   begin
      if (reset)
         vga_hold <= '0;
      else if (vga_ready)
         vga_hold <= vga_q;
   end

   assign vga_rdata = vga_ready ? vga_q : vga_hold;

   //////////////////////////////
   // Ready delay lines

   assign cpu_taps[0] = cpu_req;
   assign vga_taps[0] = vga_req;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cpu_taps[`VRAM_CPU_DELAY:1] <= '0;
         vga_taps[`VRAM_VGA_DELAY:1] <= '0;
      end
      else
      begin
         cpu_taps[`VRAM_CPU_DELAY:1] <= cpu_taps[`VRAM_CPU_DELAY-1:0];
         vga_taps[`VRAM_VGA_DELAY:1] <= vga_taps[`VRAM_VGA_DELAY-1:0];
      end
   end

   assign cpu_ready = cpu_taps[`VRAM_CPU_DELAY];
   assign vga_ready = vga_taps[`VRAM_VGA_DELAY];

endmodule

/* rtl/ram_controller.sv */
// Top level joining the SDRAM path and the video RAM

`timescale 1ns/1ps

`include "ram_defs.svh"

module ram_controller
   import mem_types_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // CPU main memory
   input  sdram_addr_t sdram_addr,
   input  ram_word_t   sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output ram_word_t   sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,

   // Video RAM, CPU side
   input  vram_addr_t  vram_cpu_addr,
   input  ram_word_t   vram_cpu_data_in,
   input  logic        vram_cpu_req,
   input  logic        vram_cpu_write,
   output ram_word_t   vram_cpu_data_out,
   output logic        vram_cpu_ready,

   // Video RAM, display side
   input  vram_addr_t  vram_vga_addr,
   input  logic        vram_vga_req,
   output ram_word_t   vram_vga_data_out,
   output logic        vram_vga_ready
);

   logic     timer_start;
   logic     timer_done;
   mem_cmd_e mem_cmd;

   //////////////////////////////
   // SDRAM path

   sdram_fsm fsm0 (
      .clk         (clk),
      .reset       (reset),
      .sdram_req   (sdram_req),
      .sdram_write (sdram_write),
      .timer_done  (timer_done),
      .timer_start (timer_start),
      .mem_cmd     (mem_cmd),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done)
   );

   access_timer timer0 (
      .clk   (clk),
      .reset (reset),
      .start (timer_start),
      .done  (timer_done)
   );

   sdram_store store0 (
      .clk     (clk),
      .reset   (reset),
      .mem_cmd (mem_cmd),
      .addr    (sdram_addr),
      .wdata   (sdram_data_in),
      .rdata   (sdram_data_out)
   );

   //////////////////////////////
   // Video RAM

   vram_dpram vram0 (
      .clk       (clk),
      .reset     (reset),
      .cpu_addr  (vram_cpu_addr),
      .cpu_wdata (vram_cpu_data_in),
      .cpu_req   (vram_cpu_req),
      .cpu_write (vram_cpu_write),
      .vga_addr  (vram_vga_addr),
      .vga_req   (vram_vga_req),
      .cpu_rdata (vram_cpu_data_out),
      .cpu_ready (vram_cpu_ready),
      .vga_rdata (vram_vga_data_out),
      .vga_ready (vram_vga_ready)
   );

endmodule

/* bench/ram_controller_tb.sv */
// Testbench for the RAM controller with LFSR stimulus, shadow models and a compare process

`timescale 1ns/1ps

`include "ram_defs.svh"

module ram_controller_tb
   import mem_types_pkg::*;
   import ctrl_types_pkg::*;
();

   localparam int TIMEOUT  = 100;
   localparam int SD_IDX_W = $clog2(`DRAM_WORDS);

   logic         clk;
   logic         reset;
   sdram_addr_t  sdram_addr;
   ram_word_t    sdram_data_in;
   logic         sdram_req;
   logic         sdram_write;
   ram_word_t    sdram_data_out;
   logic         sdram_ready;
   logic         sdram_done;
   vram_addr_t   vram_cpu_addr;
   ram_word_t    vram_cpu_data_in;
   logic         vram_cpu_req;
   logic         vram_cpu_write;
   ram_word_t    vram_cpu_data_out;
   logic         vram_cpu_ready;
   vram_addr_t   vram_vga_addr;
   logic         vram_vga_req;
   ram_word_t    vram_vga_data_out;
   logic         vram_vga_ready;

   ram_word_t    sdram_shadow [`DRAM_WORDS];
   ram_word_t    vram_shadow [`VRAM_WORDS];
   logic [15:0]  lfsr;
   int           pass_count;
   int           fail_count;
   string        chk_name_q [$];
   ram_word_t    chk_exp_q [$];
   ram_word_t    chk_act_q [$];
   event         check_ev;
   sdram_state_e fsm_state;

   ram_controller dut0 (.*);

   // For the timeout message
   assign fsm_state = dut0.fsm0.state;

   always #5 clk = ~clk;

   //////////////////////////////
   // Stimulus and reference

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output ram_word_t value);
      value = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr  = lfsr_next(lfsr);
         value = {value[`RAM_DATA_W-2:0], lfsr[0]};
      end
   endtask

   function automatic ram_word_t expected_sdram_read(input sdram_addr_t addr);
      if (int'(addr) < `DRAM_WORDS)
         return sdram_shadow[addr[SD_IDX_W-1:0]];
      return '1;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check(input string name, input ram_word_t exp, input ram_word_t act);
      chk_name_q.push_back(name);
      chk_exp_q.push_back(exp);
      chk_act_q.push_back(act);
      -> check_ev;
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check(name, ram_word_t'(exp), ram_word_t'(act));
   endtask

   //////////////////////////////
   // Compare process

   initial
   begin
      string     name;
      ram_word_t exp;
      ram_word_t act;
      forever
      begin
         @(check_ev);
         while (chk_name_q.size() != 0)
         begin
            name = chk_name_q.pop_front();
            exp  = chk_exp_q.pop_front();
            act  = chk_act_q.pop_front();
            assert (act === exp)
               pass_count = pass_count + 1;
            else
            begin
               $display("[FAIL] %s expected %h actual %h", name, exp, act);
               fail_count = fail_count + 1;
            end
         end
      end
   end

   //////////////////////////////
   // SDRAM access

   task automatic wait_sdram(input logic is_write);
      int cycles = 0;
      while (!(is_write ? sdram_done : sdram_ready) && (cycles < TIMEOUT))
      begin
         next_cycle();
         cycles++;
      end
      if (!(is_write ? sdram_done : sdram_ready))
      begin
         $display("ERROR: %s did not rise within %0d cycles, FSM stuck in %s",
                  is_write ? "sdram_done" : "sdram_ready", TIMEOUT, fsm_state.name());
         fail_count = fail_count + 1;
      end
   endtask

   // Hold the level for extra cycles, then release and see the flag fall
   task automatic sdram_access(input logic is_write, input sdram_addr_t addr,
                               input ram_word_t wdata, input int hold,
                               output ram_word_t rdata);
      string flag_name = is_write ? "sdram_done" : "sdram_ready";
      sdram_addr    = addr;
      sdram_data_in = wdata;
      sdram_write   = is_write;
      sdram_req     = !is_write;
      next_cycle();
      wait_sdram(is_write);
      rdata = sdram_data_out;
      for (int i = 0; i < hold; i++)
      begin
         next_cycle();
         check_bit(flag_name, 1'b1, is_write ? sdram_done : sdram_ready);
         if (!is_write)
            check("sdram_data_out", rdata, sdram_data_out);
      end
      sdram_req   = 1'b0;
      sdram_write = 1'b0;
      next_cycle();
      check_bit(flag_name, 1'b0, is_write ? sdram_done : sdram_ready);
      // Writes past installed memory are dropped
      if (is_write && (int'(addr) < `DRAM_WORDS))
         sdram_shadow[addr[SD_IDX_W-1:0]] = wdata;
   endtask

   task automatic end_test(input string name, input int base_fail);
      next_cycle();
      $display("Test %-24s done, %0d errors", name, fail_count - base_fail);
   endtask

   //////////////////////////////
   // Main sequence

   initial
   begin
      sdram_addr_t addrs [20];
      vram_addr_t  vaddrs [12];
      sdram_addr_t alias_addr;
      ram_word_t   value;
      ram_word_t   rdata;
      int          base_fail;

      clk              = 1'b0;
      reset            = 1'b1;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      sdram_req        = 1'b0;
      sdram_write      = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req     = 1'b0;
      vram_cpu_write   = 1'b0;
      vram_vga_addr    = '0;
      vram_vga_req     = 1'b0;
      lfsr             = 16'd57690;
      pass_count       = 0;
      fail_count       = 0;
      for (int i = 0; i < `DRAM_WORDS; i++)
         sdram_shadow[i] = '0;

      repeat (5)
         next_cycle();
      reset = 1'b0;

      base_fail = fail_count;
      check_bit("sdram_ready", 1'b0, sdram_ready);
      check_bit("sdram_done", 1'b0, sdram_done);
      check_bit("vram_cpu_ready", 1'b0, vram_cpu_ready);
      check_bit("vram_vga_ready", 1'b0, vram_vga_ready);
      check("sdram_data_out", '0, sdram_data_out);
      check("vram_vga_data_out", '0, vram_vga_data_out);
      end_test("reset values", base_fail);

      base_fail = fail_count;
      for (int i = 0; i < 20; i++)
      begin
         random_bits(SD_IDX_W, value);
         addrs[i] = sdram_addr_t'(value);
         random_bits(32, value);
         sdram_access(1'b1, addrs[i], value, 0, rdata);
      end
      for (int i = 0; i < 20; i++)
      begin
         sdram_access(1'b0, addrs[i], '0, 0, rdata);
         check("sdram_data_out", expected_sdram_read(addrs[i]), rdata);
      end
      end_test("sdram write and read", base_fail);

      base_fail = fail_count;
      random_bits(8, value);
      alias_addr = sdram_addr_t'(`DRAM_WORDS) + sdram_addr_t'(value[7:0]);
      sdram_access(1'b0, alias_addr, '0, 0, rdata);
      check("sdram_data_out", expected_sdram_read(alias_addr), rdata);
      // Upper bits set, low bits alias a written word
      random_bits(8, value);
      alias_addr = sdram_addr_t'({value[7:0] | 8'h01, addrs[0][SD_IDX_W-1:0]});
      sdram_access(1'b1, alias_addr, ~expected_sdram_read(addrs[0]), 0, rdata);
      sdram_access(1'b0, addrs[0], '0, 0, rdata);
      check("sdram_data_out", expected_sdram_read(addrs[0]), rdata);
      end_test("sdram out of range", base_fail);

      base_fail = fail_count;
      sdram_access(1'b0, addrs[1], '0, 10, rdata);
      check("sdram_data_out", expected_sdram_read(addrs[1]), rdata);
      random_bits(32, value);
      sdram_access(1'b1, addrs[2], value, 10, rdata);
      sdram_access(1'b0, addrs[2], '0, 0, rdata);
      check("sdram_data_out", expected_sdram_read(addrs[2]), rdata);
      end_test("sdram held level", base_fail);

      base_fail = fail_count;
      for (int i = 0; i < 12; i++)
      begin
         random_bits(15, value);
         vaddrs[i] = vram_addr_t'(value % `VRAM_WORDS);
         random_bits(32, value);
         vram_cpu_addr    = vaddrs[i];
         vram_cpu_data_in = value;
         vram_cpu_write   = 1'b1;
         next_cycle();
         vram_cpu_write      = 1'b0;
         vram_shadow[vaddrs[i]] = value;
      end
      for (int i = 0; i < 12; i++)
      begin
         vram_cpu_addr = vaddrs[i];
         vram_cpu_req  = 1'b1;
         for (int c = 1; c <= `VRAM_CPU_DELAY; c++)
         begin
            next_cycle();
            vram_cpu_req = 1'b0;
            check_bit("vram_cpu_ready", c == `VRAM_CPU_DELAY, vram_cpu_ready);
         end
         check("vram_cpu_data_out", vram_shadow[vaddrs[i]], vram_cpu_data_out);
         next_cycle();
      end
      end_test("vram cpu port", base_fail);

      base_fail = fail_count;
      for (int i = 0; i < 4; i++)
      begin
         vram_vga_addr = vaddrs[i];
         vram_vga_req  = 1'b1;
         check_bit("vram_vga_ready", 1'b0, vram_vga_ready);
         next_cycle();
         vram_vga_req = 1'b0;
         check_bit("vram_vga_ready", 1'b1, vram_vga_ready);
         check("vram_vga_data_out", vram_shadow[vaddrs[i]], vram_vga_data_out);
         // Word must hold while the address wanders
         for (int c = 0; c < 3; c++)
         begin
            vram_vga_addr = vaddrs[(i + c + 1) % 12];
            next_cycle();
            check_bit("vram_vga_ready", 1'b0, vram_vga_ready);
            check("vram_vga_data_out", vram_shadow[vaddrs[i]], vram_vga_data_out);
         end
      end
      end_test("vram vga port", base_fail);

      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* ram_controller.f */
+incdir+rtl
rtl/mem_types_pkg.sv
rtl/ctrl_types_pkg.sv
rtl/access_timer.sv
rtl/sdram_store.sv
rtl/sdram_fsm.sv
rtl/vram_dpram.sv
rtl/ram_controller.sv
bench/ram_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the RAM controller testbench with Verilator and run it

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f ram_controller.f \
   --top-module ram_controller_tb \
   -o ram_controller_sim

./obj_dir/ram_controller_sim > sim.log
cat sim.log

if grep -q "All tests passed!" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
